//--- verilog/audio_synth_pkg.sv
package audio_synth_pkg;

  // Signed audio sample as sent to the codec
  typedef logic signed [15:0] sample_t;

  // Codec register byte offsets from the base address
  parameter logic [31:0] REG_FIFOSPACE = 32'd4;
  parameter logic [31:0] REG_LEFT      = 32'd8;
  parameter logic [31:0] REG_RIGHT     = 32'd12;

  // Write space fields in the FIFO-space word
  parameter int WSRC_LSB = 16;
  parameter int WSRC_MSB = 23;
  parameter int WSLC_LSB = 24;
  parameter int WSLC_MSB = 31;

  // Bus master FSM
  typedef enum logic [2:0] {
    IDLE,
    POLL,
    WRITE_LEFT,
    WRITE_RIGHT,
    ADVANCE
  } master_state_e;

endpackage

//--- verilog/tone_channel.sv
`timescale 1ns/100ps

module tone_channel (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [31:0]           delta,
  input  logic                  delta_mode,
  input  logic [9:0]            wave_max,
  input  logic                  step,
  output audio_synth_pkg::sample_t sample
);

  logic [31:0]        phase;
  logic signed [10:0] level;
  logic               dir_up;

  logic signed [11:0] level_wide;
  logic signed [11:0] inc;
  logic signed [11:0] peak;
  logic signed [11:0] level_raw;
  logic signed [11:0] level_next;
  logic               dir_next;

  // Work one bit wider so the step itself cannot wrap
  assign level_wide = {level[10], level};
  assign inc        = {2'b00, delta[9:0]};
  assign peak       = {2'b00, wave_max};

  always_comb begin
    level_next = 12'sd0;
    dir_next   = dir_up;
    if (dir_up) begin
      level_raw = level_wide + inc;
      if (level_raw >= peak) begin
        level_next = peak;
        dir_next   = 1'b0;
      end else begin
        level_next = level_raw;
      end
    end else begin
      level_raw = level_wide - inc;
      if (level_raw <= -peak) begin
        level_next = -peak;
        dir_next   = 1'b1;
      end else begin
        level_next = level_raw;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase  <= 32'd0;
      level  <= 11'sd0;
      dir_up <= 1'b1;
    end else if (step) begin
      // Phase wraps naturally at 2^32
      phase  <= phase + delta;
      level  <= level_next[10:0];
      dir_up <= dir_next;
    end
  end

  // Sawtooth from the phase MSBs, triangle scaled up by 32
  assign sample = delta_mode ? {level, 5'b00000} : phase[31:16];

endmodule

//--- verilog/audio_bus_master.sv
`timescale 1ns/100ps

module audio_bus_master #(
  parameter logic [31:0] AUDIO_BASE = 32'hFF20_3040
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  audio_synth_pkg::sample_t sample_left,
  input  audio_synth_pkg::sample_t sample_right,
  input  logic                     out_sel,
  output logic                     step,
  output logic [31:0]              bus_addr,
  output logic [3:0]               bus_byte_enable,
  output logic                     bus_read,
  output logic                     bus_write,
  output logic [31:0]              bus_write_data,
  input  logic                     bus_ack,
  input  logic [31:0]              bus_read_data
);

  audio_synth_pkg::master_state_e state;

  audio_synth_pkg::sample_t left_q;
  audio_synth_pkg::sample_t right_q;
  audio_synth_pkg::sample_t mono;

  logic signed [16:0] sum;
  logic               space_ok;
  logic               latch;

  // One extra bit keeps the sum from overflowing
  assign sum  = {sample_left[15], sample_left} + {sample_right[15], sample_right};
  assign mono = audio_synth_pkg::sample_t'(sum >>> 1);

  assign space_ok =
    (bus_read_data[audio_synth_pkg::WSLC_MSB:audio_synth_pkg::WSLC_LSB] != 8'd0) &&
    (bus_read_data[audio_synth_pkg::WSRC_MSB:audio_synth_pkg::WSRC_LSB] != 8'd0);

  assign latch = (state == audio_synth_pkg::POLL) && bus_read && bus_ack && space_ok;

  assign step            = (state == audio_synth_pkg::ADVANCE);
  assign bus_byte_enable = 4'hF;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= audio_synth_pkg::IDLE;
      bus_read  <= 1'b0;
      bus_write <= 1'b0;
    end else begin
      case (state)
        audio_synth_pkg::IDLE: begin
          state    <= audio_synth_pkg::POLL;
          bus_read <= 1'b1;
        end
        audio_synth_pkg::POLL: begin
          if (!bus_read) begin
            bus_read <= 1'b1;
          end else if (bus_ack) begin
            bus_read <= 1'b0;
            if (space_ok) begin
              state <= audio_synth_pkg::WRITE_LEFT;
            end
          end
        end
        audio_synth_pkg::WRITE_LEFT: begin
          if (!bus_write) begin
            bus_write <= 1'b1;
          end else if (bus_ack) begin
            bus_write <= 1'b0;
            state     <= audio_synth_pkg::WRITE_RIGHT;
          end
        end
        audio_synth_pkg::WRITE_RIGHT: begin
          if (!bus_write) begin
            bus_write <= 1'b1;
          end else if (bus_ack) begin
            bus_write <= 1'b0;
            state     <= audio_synth_pkg::ADVANCE;
          end
        end
        audio_synth_pkg::ADVANCE: begin
          state    <= audio_synth_pkg::POLL;
          bus_read <= 1'b1;
        end
        default: begin
          state     <= audio_synth_pkg::IDLE;
          bus_read  <= 1'b0;
          bus_write <= 1'b0;
        end
      endcase
    end
  end

  // Frame samples, out_sel sampled here too
  always_ff @(posedge clk) begin
    if (latch) begin
      left_q  <= out_sel ? mono : sample_left;
      right_q <= out_sel ? mono : sample_right;
    end
  end

  // Address and data only change while no request is up
  always_ff @(posedge clk) begin
    if (state == audio_synth_pkg::IDLE || state == audio_synth_pkg::ADVANCE ||
        (state == audio_synth_pkg::POLL && !bus_read)) begin
      bus_addr       <= AUDIO_BASE + audio_synth_pkg::REG_FIFOSPACE;
      bus_write_data <= 32'd0;
    end else if (state == audio_synth_pkg::WRITE_LEFT && !bus_write) begin
      bus_addr       <= AUDIO_BASE + audio_synth_pkg::REG_LEFT;
      bus_write_data <= {{16{left_q[15]}}, left_q};
    end else if (state == audio_synth_pkg::WRITE_RIGHT && !bus_write) begin
      bus_addr       <= AUDIO_BASE + audio_synth_pkg::REG_RIGHT;
      bus_write_data <= {{16{right_q[15]}}, right_q};
    end
  end

endmodule

//--- verilog/audio_synth_top.sv
`timescale 1ns/100ps

module audio_synth_top #(
  parameter logic [31:0] AUDIO_BASE = 32'hFF20_3040
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] delta_left,
  input  logic [31:0] delta_right,
  input  logic        delta_mode_left,
  input  logic        delta_mode_right,
  input  logic [9:0]  triangle_wave_max_left,
  input  logic [9:0]  triangle_wave_max_right,
  input  logic        out_sel,
  output logic [31:0] bus_addr,
  output logic [3:0]  bus_byte_enable,
  output logic        bus_read,
  output logic        bus_write,
  output logic [31:0] bus_write_data,
  input  logic        bus_ack,
  input  logic [31:0] bus_read_data
);

  audio_synth_pkg::sample_t sample_left;
  audio_synth_pkg::sample_t sample_right;
  logic                     step;

  tone_channel left_channel (
    .clk        (clk),
    .rst_n      (rst_n),
    .delta      (delta_left),
    .delta_mode (delta_mode_left),
    .wave_max   (triangle_wave_max_left),
    .step       (step),
    .sample     (sample_left)
  );

  tone_channel right_channel (
    .clk        (clk),
    .rst_n      (rst_n),
    .delta      (delta_right),
    .delta_mode (delta_mode_right),
    .wave_max   (triangle_wave_max_right),
    .step       (step),
    .sample     (sample_right)
  );

  audio_bus_master #(
    .AUDIO_BASE (AUDIO_BASE)
  ) bus_master (
    .clk             (clk),
    .rst_n           (rst_n),
    .sample_left     (sample_left),
    .sample_right    (sample_right),
    .out_sel         (out_sel),
    .step            (step),
    .bus_addr        (bus_addr),
    .bus_byte_enable (bus_byte_enable),
    .bus_read        (bus_read),
    .bus_write       (bus_write),
    .bus_write_data  (bus_write_data),
    .bus_ack         (bus_ack),
    .bus_read_data   (bus_read_data)
  );

endmodule

//--- verif/audio_synth_assert.sv
`timescale 1ns/100ps

module audio_synth_assert (
  input logic                           clk,
  input logic                           rst_n,
  input audio_synth_pkg::master_state_e state,
  input logic                           step,
  input logic [31:0]                    bus_addr,
  input logic                           bus_read,
  input logic                           bus_write,
  input logic [31:0]                    bus_write_data,
  input logic                           bus_ack
);

  no_read_with_write: assert property (@(posedge clk) disable iff (!rst_n)
    !(bus_read && bus_write))
    else $error("bus_read and bus_write high in the same cycle");

  // Request, address and data hold until the ack
  request_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ((bus_read || bus_write) && !bus_ack) |=>
      ($stable(bus_read) && $stable(bus_write) &&
       $stable(bus_addr) && $stable(bus_write_data)))
    else $error("Bus request changed before its ack");

  // step closes a frame, right after the right-data write is acked
  step_in_advance: assert property (@(posedge clk) disable iff (!rst_n)
    step |-> ((state == audio_synth_pkg::ADVANCE) && $past(bus_write && bus_ack)))
    else $error("step pulsed outside ADVANCE or without a write ack before it");

endmodule

bind audio_bus_master audio_synth_assert bus_checks (
  .clk             (clk),
  .rst_n           (rst_n),
  .state           (state),
  .step            (step),
  .bus_addr        (bus_addr),
  .bus_read        (bus_read),
  .bus_write       (bus_write),
  .bus_write_data  (bus_write_data),
  .bus_ack         (bus_ack)
);

//--- verif/audio_synth_tb.sv
`timescale 1ns/100ps

module audio_synth_tb;

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 16;
  localparam int          NUM_ROWS     = 5;
  localparam int          FRAMES       = 5;
  localparam logic [31:0] CODEC_BASE   = 32'h0000_1000;
  // 40 cycles per frame, plus each row's reset
  localparam int          WATCHDOG_CYCLES = NUM_ROWS * (FRAMES * 40 + RESET_CYCLES);

  typedef struct {
    logic [31:0]              delta_l;
    logic                     mode_l;
    logic [9:0]               peak_l;
    logic [31:0]              delta_r;
    logic                     mode_r;
    logic [9:0]               peak_r;
    logic                     out_sel;
    logic                     slow;
    audio_synth_pkg::sample_t exp_l [FRAMES];
    audio_synth_pkg::sample_t exp_r [FRAMES];
  } row_t;

  logic        clk;
  logic        rst_n;
  logic [31:0] delta_left;
  logic [31:0] delta_right;
  logic        delta_mode_left;
  logic        delta_mode_right;
  logic [9:0]  triangle_wave_max_left;
  logic [9:0]  triangle_wave_max_right;
  logic        out_sel;
  logic [31:0] bus_addr;
  logic [3:0]  bus_byte_enable;
  logic        bus_read;
  logic        bus_write;
  logic [31:0] bus_write_data;
  logic        bus_ack;
  logic [31:0] bus_read_data;

  integer seed = 32'h55b8;
  logic   cur_slow;
  int     frame_phase;
  int     left_count;
  int     right_count;
  int     row_empty_polls;

  audio_synth_pkg::sample_t got_left  [FRAMES];
  audio_synth_pkg::sample_t got_right [FRAMES];

  // Sawtooth stereo, triangle, mixed, mono, then full FIFO with slow acks
  row_t rows [NUM_ROWS] = '{
    '{32'h0800_0000, 1'b0, 10'd0, 32'h3000_1234, 1'b0, 10'd0, 1'b0, 1'b0,
      '{16'h0000, 16'h0800, 16'h1000, 16'h1800, 16'h2000},
      '{16'h0000, 16'h3000, 16'h6000, 16'h9000, 16'hC000}},
    '{32'd100, 1'b1, 10'd250, 32'h0000_0190, 1'b1, 10'd300, 1'b0, 1'b0,
      '{16'h0000, 16'h0C80, 16'h1900, 16'h1F40, 16'h12C0},
      '{16'h0000, 16'h2580, 16'hF380, 16'hDA80, 16'h0C80}},
    '{32'h2000_0000, 1'b0, 10'd500, 32'h2000_0040, 1'b1, 10'd100, 1'b0, 1'b0,
      '{16'h0000, 16'h2000, 16'h4000, 16'h6000, 16'h8000},
      '{16'h0000, 16'h0800, 16'h0C80, 16'h0480, 16'hFC80}},
    '{32'h1000_0000, 1'b0, 10'd0, 32'h5000_8000, 1'b0, 10'd0, 1'b1, 1'b0,
      '{16'h0000, 16'h3000, 16'hE000, 16'h1000, 16'h4001},
      '{16'h0000, 16'h3000, 16'hE000, 16'h1000, 16'h4001}},
    '{32'hFFFF_0000, 1'b0, 10'd0, 32'h0001_8000, 1'b0, 10'd0, 1'b0, 1'b1,
      '{16'h0000, 16'hFFFF, 16'hFFFE, 16'hFFFD, 16'hFFFC},
      '{16'h0000, 16'h0001, 16'h0003, 16'h0004, 16'h0006}}
  };

  audio_synth_top #(
    .AUDIO_BASE (CODEC_BASE)
  ) DUT (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .delta_left              (delta_left),
    .delta_right             (delta_right),
    .delta_mode_left         (delta_mode_left),
    .delta_mode_right        (delta_mode_right),
    .triangle_wave_max_left  (triangle_wave_max_left),
    .triangle_wave_max_right (triangle_wave_max_right),
    .out_sel                 (out_sel),
    .bus_addr                (bus_addr),
    .bus_byte_enable         (bus_byte_enable),
    .bus_read                (bus_read),
    .bus_write               (bus_write),
    .bus_write_data          (bus_write_data),
    .bus_ack                 (bus_ack),
    .bus_read_data           (bus_read_data)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_sample(input string name, input audio_synth_pkg::sample_t actual,
                              input audio_synth_pkg::sample_t expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch: %s actual=%h expected=%h", name, actual, expected));
    end
  endtask

  task automatic check_addr(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch: %s actual=%h expected=%h", name, actual, expected));
    end
  endtask

  task automatic check_byte_enable(input string name, input logic [3:0] actual,
                                   input logic [3:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch: %s actual=%h expected=%h", name, actual, expected));
    end
  endtask

  // Slow rows report a full FIFO half the time
  function automatic logic [31:0] fifo_word(input logic slow);
    logic [31:0] word;
    logic [7:0]  wslc;
    logic [7:0]  wsrc;
    if (slow) begin
      wslc = (($random(seed) & 1) != 0) ? 8'd0 : 8'd32;
      wsrc = wslc;
    end else begin
      wslc = (($random(seed) & 3) == 0) ? 8'd0 : 8'd48;
      wsrc = (($random(seed) & 3) == 0) ? 8'd0 : 8'd48;
    end
    word = 32'd0;
    word[audio_synth_pkg::WSLC_MSB:audio_synth_pkg::WSLC_LSB] = wslc;
    word[audio_synth_pkg::WSRC_MSB:audio_synth_pkg::WSRC_LSB] = wsrc;
    return word;
  endfunction

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Codec model, acks 1 to 4 cycles after the request shows up
  initial begin : codec_model
    int          delay;
    logic [31:0] word;
    bus_ack       = 1'b0;
    bus_read_data = 32'd0;
    forever begin
      @(posedge clk);
      #2;
      if (!rst_n) begin
        frame_phase = 0;
      end else if (bus_read || bus_write) begin
        check_byte_enable("bus_byte_enable", bus_byte_enable, 4'hF);
        delay = cur_slow ? 4 : 1 + ($unsigned($random(seed)) % 4);
        repeat (delay) @(posedge clk);
        #2;
        if (rst_n && bus_read) begin
          check_addr("bus_addr on FIFO-space read", bus_addr,
                     CODEC_BASE + audio_synth_pkg::REG_FIFOSPACE);
          if (frame_phase != 0) begin
            abort_run("FIFO-space read issued before the frame's right write");
          end
          word = fifo_word(cur_slow);
          if (word[audio_synth_pkg::WSLC_MSB:audio_synth_pkg::WSLC_LSB] == 8'd0 ||
              word[audio_synth_pkg::WSRC_MSB:audio_synth_pkg::WSRC_LSB] == 8'd0) begin
            row_empty_polls++;
          end else begin
            frame_phase = 1;
          end
          bus_read_data = word;
          bus_ack       = 1'b1;
        end else if (rst_n && bus_write) begin
          if (bus_write_data[31:16] !== {16{bus_write_data[15]}}) begin
            abort_run("Write data is not sign-extended to 32 bits");
          end
          if (frame_phase == 1) begin
            check_addr("bus_addr on left write", bus_addr,
                       CODEC_BASE + audio_synth_pkg::REG_LEFT);
            if (left_count < FRAMES) begin
              got_left[left_count] = bus_write_data[15:0];
            end
            left_count++;
            frame_phase = 2;
          end else if (frame_phase == 2) begin
            check_addr("bus_addr on right write", bus_addr,
                       CODEC_BASE + audio_synth_pkg::REG_RIGHT);
            if (right_count < FRAMES) begin
              got_right[right_count] = bus_write_data[15:0];
            end
            right_count++;
            frame_phase = 0;
          end else begin
            abort_run("Data write issued without FIFO space");
          end
          bus_ack = 1'b1;
        end
        @(posedge clk);
        #2;
        bus_ack       = 1'b0;
        bus_read_data = 32'd0;
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run("Watchdog expired, the bus stalled before all frames were written");
  end

  initial begin : main_seq
    int r;
    int k;
    rst_n                   = 1'b0;
    delta_left              = 32'd0;
    delta_right             = 32'd0;
    delta_mode_left         = 1'b0;
    delta_mode_right        = 1'b0;
    triangle_wave_max_left  = 10'd0;
    triangle_wave_max_right = 10'd0;
    out_sel                 = 1'b0;
    cur_slow                = 1'b0;
    frame_phase             = 0;
    left_count              = 0;
    right_count             = 0;
    row_empty_polls         = 0;
    for (r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk);
      #2;
      rst_n                   = 1'b0;
      delta_left              = rows[r].delta_l;
      delta_mode_left         = rows[r].mode_l;
      triangle_wave_max_left  = rows[r].peak_l;
      delta_right             = rows[r].delta_r;
      delta_mode_right        = rows[r].mode_r;
      triangle_wave_max_right = rows[r].peak_r;
      out_sel                 = rows[r].out_sel;
      cur_slow                = rows[r].slow;
      left_count              = 0;
      right_count             = 0;
      row_empty_polls         = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;
      wait (right_count >= FRAMES);
      for (k = 0; k < FRAMES; k++) begin
        check_sample($sformatf("left sample row %0d frame %0d", r, k),
                     got_left[k], rows[r].exp_l[k]);
        check_sample($sformatf("right sample row %0d frame %0d", r, k),
                     got_right[k], rows[r].exp_r[k]);
      end
      if (rows[r].slow && row_empty_polls == 0) begin
        abort_run("No poll found the FIFO full during the slow row");
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- project.f
verilog/audio_synth_pkg.sv
verilog/tone_channel.sv
verilog/audio_bus_master.sv
verilog/audio_synth_top.sv
verif/audio_synth_assert.sv
verif/audio_synth_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module audio_synth_tb \
  -f project.f \
  --Mdir obj_dir -o audio_synth_sim

./obj_dir/audio_synth_sim
